/* hw/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// memory bus word
`define DCACHE_WORD_W 32

// cache geometry
`define DCACHE_SETS 8
`define DCACHE_IDX_W 3
`define DCACHE_BLK_WORDS 2

// 32-bit address less index, block offset and byte offset
`define DCACHE_TAG_W 26

`endif

/* hw/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // byte address split for lookup
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0] tag;
        logic [`DCACHE_IDX_W-1:0] idx;
        logic                     blkoff;
        logic [1:0]               bytoff;
    } dcache_addr_t;

    // one line of one way
    typedef struct packed {
        logic                               valid;
        logic                               dirty;
        logic [`DCACHE_TAG_W-1:0]           tag;
        word_t [`DCACHE_BLK_WORDS-1:0]      data;
    } dcache_frame_t;

    typedef enum logic [4:0] {
        IDLE,
        WB_ONE,
        WB_TWO,
        FILL_ONE,
        FILL_TWO,
        FLUSH_CHECK,
        FLUSH_ONE,
        FLUSH_TWO,
        DONE
    } ctrl_state_t;

endpackage

/* hw/dcache_ways.sv */
`include "dcache_settings.svh"

module dcache_ways (
    input  logic                      CLK,
    input  logic                      n_rst,
    input  dcache_pkg::word_t         dmemaddr,
    input  logic                      dmemREN,
    input  logic                      dmemWEN,
    input  dcache_pkg::word_t         dmemstore,
    input  logic                      lookup_en,
    input  logic [`DCACHE_IDX_W-1:0]  port_idx,
    input  logic                      port_way,
    input  logic                      port_word,
    input  logic                      clean,
    input  logic                      fill_en,
    input  logic                      fill_word,
    input  dcache_pkg::word_t         dload,
    output logic                      dhit,
    output dcache_pkg::word_t         dmemload,
    output logic                      miss,
    output logic                      victim_way,
    output logic [`DCACHE_TAG_W-1:0]  port_tag,
    output dcache_pkg::word_t         port_data,
    output logic [1:0]                dirty_pair
);

    // two ways, one frame per set in each
    dcache_pkg::dcache_frame_t frames [2][`DCACHE_SETS];

    // per set, the way to replace next
    logic [`DCACHE_SETS-1:0] lru;

    dcache_pkg::dcache_addr_t addr;
    logic [1:0]               way_hit;
    logic                     hit_way;
    logic                     req;

    assign addr = dcache_pkg::dcache_addr_t'(dmemaddr);
    assign req  = dmemREN | dmemWEN;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = frames[w][addr.idx].valid &&
                         (frames[w][addr.idx].tag == addr.tag);
        end
    end

    // both ways never hold the same tag
    assign hit_way = ~way_hit[0];

    assign dhit = lookup_en & req & (|way_hit);
    assign miss = lookup_en & req & ~(|way_hit);

    assign dmemload = dhit ? frames[hit_way][addr.idx].data[addr.blkoff] : '0;

    assign victim_way = lru[addr.idx];

    // controller side read port
    assign port_tag   = frames[port_way][port_idx].tag;
    assign port_data  = frames[port_way][port_idx].data[port_word];
    assign dirty_pair = {frames[1][port_idx].dirty, frames[0][port_idx].dirty};

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                frames[0][s] <= '0;
                frames[1][s] <= '0;
            end
            lru <= '0;
        end else begin
            if (dhit) begin
                // other way becomes the victim
                lru[addr.idx] <= ~hit_way;
                if (dmemWEN) begin
                    frames[hit_way][addr.idx].data[addr.blkoff] <= dmemstore;
                    frames[hit_way][addr.idx].dirty             <= 1'b1;
                end
            end

            if (fill_en) begin
                frames[victim_way][addr.idx].data[fill_word] <= dload;
                frames[victim_way][addr.idx].dirty           <= 1'b0;
                if (fill_word) begin
                    frames[victim_way][addr.idx].tag   <= addr.tag;
                    frames[victim_way][addr.idx].valid <= 1'b1;
                    lru[addr.idx]                      <= ~victim_way;
                end else begin
                    // half-filled line must not hit
                    frames[victim_way][addr.idx].valid <= 1'b0;
                end
            end

            // block now matches memory
            if (clean) begin
                frames[port_way][port_idx].dirty <= 1'b0;
            end
        end
    end

endmodule

/* hw/dcache_ctrl.sv */
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                      CLK,
    input  logic                      n_rst,
    input  logic                      halt,
    input  dcache_pkg::word_t         dmemaddr,
    input  logic                      dmemREN,
    input  logic                      dmemWEN,
    input  logic                      miss,
    input  logic                      victim_way,
    input  logic [`DCACHE_TAG_W-1:0]  port_tag,
    input  dcache_pkg::word_t         port_data,
    input  logic [1:0]                dirty_pair,
    input  logic                      dwait,
    output logic                      lookup_en,
    output logic [`DCACHE_IDX_W-1:0]  port_idx,
    output logic                      port_way,
    output logic                      port_word,
    output logic                      clean,
    output logic                      fill_en,
    output logic                      fill_word,
    output logic                      flushed,
    output logic                      dREN,
    output logic                      dWEN,
    output dcache_pkg::word_t         daddr,
    output dcache_pkg::word_t         dstore
);

    dcache_pkg::ctrl_state_t  state, next_state;
    logic [`DCACHE_IDX_W-1:0] flush_idx, next_flush_idx;
    logic                     next_dREN, next_dWEN;
    dcache_pkg::word_t        next_daddr, next_dstore;

    dcache_pkg::dcache_addr_t cur_addr;
    dcache_pkg::dcache_addr_t wb_addr;
    dcache_pkg::dcache_addr_t fill_addr;
    logic                     flushing;
    logic                     req;

    assign cur_addr = dcache_pkg::dcache_addr_t'(dmemaddr);
    assign req      = dmemREN | dmemWEN;

    assign flushing = (state == dcache_pkg::FLUSH_CHECK) ||
                      (state == dcache_pkg::FLUSH_ONE) ||
                      (state == dcache_pkg::FLUSH_TWO) ||
                      (state == dcache_pkg::DONE);

    // during the sweep way 0 goes first while it is dirty
    assign port_idx  = flushing ? flush_idx : cur_addr.idx;
    assign port_way  = flushing ? ~dirty_pair[0] : victim_way;
    assign port_word = (state == dcache_pkg::WB_ONE) || (state == dcache_pkg::FLUSH_ONE);

    assign lookup_en = (state == dcache_pkg::IDLE) && !halt;

    assign fill_en   = ((state == dcache_pkg::FILL_ONE) || (state == dcache_pkg::FILL_TWO))
                       && !dwait;
    assign fill_word = (state == dcache_pkg::FILL_TWO);

    assign clean = ((state == dcache_pkg::WB_TWO) || (state == dcache_pkg::FLUSH_TWO))
                   && !dwait;

    assign flushed = (state == dcache_pkg::DONE);

    // address of the word port_data currently shows
    always_comb begin
        wb_addr        = '0;
        wb_addr.tag    = port_tag;
        wb_addr.idx    = port_idx;
        wb_addr.blkoff = port_word;
    end

    always_comb begin
        fill_addr        = cur_addr;
        fill_addr.blkoff = (state == dcache_pkg::FILL_ONE);
        fill_addr.bytoff = '0;
    end

    always_comb begin
        next_state     = state;
        next_flush_idx = flush_idx;
        next_dREN      = dREN;
        next_dWEN      = dWEN;
        next_daddr     = daddr;
        next_dstore    = dstore;

        case (state)
            dcache_pkg::IDLE: begin
                if (halt) begin
                    next_state = dcache_pkg::FLUSH_CHECK;
                end else if (req && miss) begin
                    if (dirty_pair[victim_way]) begin
                        next_state  = dcache_pkg::WB_ONE;
                        next_dWEN   = 1'b1;
                        next_daddr  = dcache_pkg::word_t'(wb_addr);
                        next_dstore = port_data;
                    end else begin
                        next_state = dcache_pkg::FILL_ONE;
                        next_dREN  = 1'b1;
                        next_daddr = dcache_pkg::word_t'(fill_addr);
                    end
                end
            end
            dcache_pkg::WB_ONE: begin
                if (!dwait) begin
                    next_state  = dcache_pkg::WB_TWO;
                    next_daddr  = dcache_pkg::word_t'(wb_addr);
                    next_dstore = port_data;
                end
            end
            dcache_pkg::WB_TWO: begin
                // victim written, fetch the missing block
                if (!dwait) begin
                    next_state  = dcache_pkg::FILL_ONE;
                    next_dWEN   = 1'b0;
                    next_dREN   = 1'b1;
                    next_daddr  = dcache_pkg::word_t'(fill_addr);
                    next_dstore = '0;
                end
            end
            dcache_pkg::FILL_ONE: begin
                if (!dwait) begin
                    next_state = dcache_pkg::FILL_TWO;
                    next_daddr = dcache_pkg::word_t'(fill_addr);
                end
            end
            dcache_pkg::FILL_TWO: begin
                if (!dwait) begin
                    next_state = dcache_pkg::IDLE;
                    next_dREN  = 1'b0;
                    next_daddr = '0;
                end
            end
            dcache_pkg::FLUSH_CHECK: begin
                if (|dirty_pair) begin
                    next_state  = dcache_pkg::FLUSH_ONE;
                    next_dWEN   = 1'b1;
                    next_daddr  = dcache_pkg::word_t'(wb_addr);
                    next_dstore = port_data;
                end else if (flush_idx == `DCACHE_IDX_W'(`DCACHE_SETS - 1)) begin
                    next_state = dcache_pkg::DONE;
                end else begin
                    next_flush_idx = flush_idx + 1'b1;
                end
            end
            dcache_pkg::FLUSH_ONE: begin
                if (!dwait) begin
                    next_state  = dcache_pkg::FLUSH_TWO;
                    next_daddr  = dcache_pkg::word_t'(wb_addr);
                    next_dstore = port_data;
                end
            end
            dcache_pkg::FLUSH_TWO: begin
                // same set again, the other way may still be dirty
                if (!dwait) begin
                    next_state  = dcache_pkg::FLUSH_CHECK;
                    next_dWEN   = 1'b0;
                    next_daddr  = '0;
                    next_dstore = '0;
                end
            end
            dcache_pkg::DONE: begin
                next_state = dcache_pkg::DONE;
            end
            default: begin
                next_state = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state     <= dcache_pkg::IDLE;
            flush_idx <= '0;
            dREN      <= 1'b0;
            dWEN      <= 1'b0;
            daddr     <= '0;
            dstore    <= '0;
        end else begin
            state     <= next_state;
            flush_idx <= next_flush_idx;
            dREN      <= next_dREN;
            dWEN      <= next_dWEN;
            daddr     <= next_daddr;
            dstore    <= next_dstore;
        end
    end

endmodule

/* hw/dcache.sv */
`include "dcache_settings.svh"

module dcache (
    input  logic               CLK,
    input  logic               n_rst,
    input  logic               halt,
    input  logic               dmemREN,
    input  logic               dmemWEN,
    input  dcache_pkg::word_t  dmemaddr,
    input  dcache_pkg::word_t  dmemstore,
    input  logic               dwait,
    input  dcache_pkg::word_t  dload,
    output logic               dhit,
    output dcache_pkg::word_t  dmemload,
    output logic               flushed,
    output logic               dREN,
    output logic               dWEN,
    output dcache_pkg::word_t  daddr,
    output dcache_pkg::word_t  dstore
);

    // controller to storage
    logic                     lookup_en;
    logic [`DCACHE_IDX_W-1:0] port_idx;
    logic                     port_way;
    logic                     port_word;
    logic                     clean;
    logic                     fill_en;
    logic                     fill_word;

    // storage to controller
    logic                     miss;
    logic                     victim_way;
    logic [`DCACHE_TAG_W-1:0] port_tag;
    dcache_pkg::word_t        port_data;
    logic [1:0]               dirty_pair;

    dcache_ways ways0 (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .dmemaddr   (dmemaddr),
        .dmemREN    (dmemREN),
        .dmemWEN    (dmemWEN),
        .dmemstore  (dmemstore),
        .lookup_en  (lookup_en),
        .port_idx   (port_idx),
        .port_way   (port_way),
        .port_word  (port_word),
        .clean      (clean),
        .fill_en    (fill_en),
        .fill_word  (fill_word),
        .dload      (dload),
        .dhit       (dhit),
        .dmemload   (dmemload),
        .miss       (miss),
        .victim_way (victim_way),
        .port_tag   (port_tag),
        .port_data  (port_data),
        .dirty_pair (dirty_pair)
    );

    dcache_ctrl ctrl0 (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .halt       (halt),
        .dmemaddr   (dmemaddr),
        .dmemREN    (dmemREN),
        .dmemWEN    (dmemWEN),
        .miss       (miss),
        .victim_way (victim_way),
        .port_tag   (port_tag),
        .port_data  (port_data),
        .dirty_pair (dirty_pair),
        .dwait      (dwait),
        .lookup_en  (lookup_en),
        .port_idx   (port_idx),
        .port_way   (port_way),
        .port_word  (port_word),
        .clean      (clean),
        .fill_en    (fill_en),
        .fill_word  (fill_word),
        .flushed    (flushed),
        .dREN       (dREN),
        .dWEN       (dWEN),
        .daddr      (daddr),
        .dstore     (dstore)
    );

endmodule

/* testbench/dcache_assert.sv */
module dcache_assert (
    input logic              CLK,
    input logic              n_rst,
    input logic              dREN,
    input logic              dWEN,
    input logic              dwait,
    input logic              flushed,
    input dcache_pkg::word_t daddr,
    input dcache_pkg::word_t dstore
);
    timeunit 1ns;
    timeprecision 100ps;

    // one bus direction at a time
    a_one_direction: assert property (@(posedge CLK) disable iff (!n_rst) !(dREN && dWEN))
        else $error("dREN and dWEN are high together");

    // flushed stays up until reset
    a_flushed_holds: assert property (@(posedge CLK) disable iff (!n_rst) flushed |=> flushed)
        else $error("flushed fell without a reset");

    // stalled request keeps address and data
    a_stall_stable: assert property (@(posedge CLK) disable iff (!n_rst)
        (dREN || dWEN) && dwait |=> $stable(daddr) && $stable(dstore))
        else $error("daddr or dstore changed while dwait was high");

endmodule

bind dcache dcache_assert assert0 (
    .CLK     (CLK),
    .n_rst   (n_rst),
    .dREN    (dREN),
    .dWEN    (dWEN),
    .dwait   (dwait),
    .flushed (flushed),
    .daddr   (daddr),
    .dstore  (dstore)
);

/* testbench/dcache_tb.sv */
module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 1000;

    logic              CLK;
    logic              n_rst;
    logic              halt;
    logic              dmemREN;
    logic              dmemWEN;
    dcache_pkg::word_t dmemaddr;
    dcache_pkg::word_t dmemstore;
    logic              dwait;
    dcache_pkg::word_t dload;
    logic              dhit;
    dcache_pkg::word_t dmemload;
    logic              flushed;
    logic              dREN;
    logic              dWEN;
    dcache_pkg::word_t daddr;
    dcache_pkg::word_t dstore;

    // memory model state
    dcache_pkg::word_t mem [dcache_pkg::word_t];
    int                flush_writes [dcache_pkg::word_t];
    bit                flush_active;
    integer            seed;

    // golden operations and final memory words
    logic [7:0]        op_kind [$];
    dcache_pkg::word_t op_addr [$];
    dcache_pkg::word_t op_data [$];
    dcache_pkg::word_t fin_addr [$];
    dcache_pkg::word_t fin_data [$];

    int errors;
    int checks;
    int tests;
    int failed_tests;
    bit timed_out;

    dcache dut0 (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic dcache_pkg::word_t mem_word(input dcache_pkg::word_t addr);
        if (mem.exists(addr)) return mem[addr];
        return addr ^ 32'hA5A50000;
    endfunction

    task automatic check_value(input string name, input dcache_pkg::word_t expected,
                               input dcache_pkg::word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error at %0d ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s to go high.", WAIT_LIMIT, what);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic finish_test(input string desc, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests, desc);
        end else begin
            failed_tests++;
            $display("test %0d %s: fail", tests, desc);
        end
    endtask

    task automatic load_golden();
        int                fd;
        int                fields;
        string             line;
        logic [7:0]        kind;
        dcache_pkg::word_t addr;
        dcache_pkg::word_t data;
        fd = $fopen("testbench/dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/dcache_golden.txt for reading.");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            fields = $sscanf(line, "%c %h %h", kind, addr, data);
            if (fields != 3) continue;
            if (kind == "M") begin
                fin_addr.push_back(addr);
                fin_data.push_back(data);
            end else begin
                op_kind.push_back(kind);
                op_addr.push_back(addr);
                op_data.push_back(data);
            end
        end
        $fclose(fd);
    endtask

    // request held until dhit, sampled at the falling edge
    task automatic run_op(input logic [7:0] kind, input dcache_pkg::word_t addr,
                          input dcache_pkg::word_t data);
        int cycles;
        dmemaddr  = addr;
        dmemREN   = (kind == "R");
        dmemWEN   = (kind == "W");
        dmemstore = (kind == "W") ? data : '0;
        cycles    = 0;
        @(negedge CLK);
        while (!dhit && cycles < WAIT_LIMIT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!dhit) begin
            report_timeout("dhit");
        end else if (kind == "R") begin
            check_value("dmemload", data, dmemload);
        end
        @(posedge CLK);
        #1;
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
    endtask

    // memory model, one transfer at a time with random stalls
    initial begin
        int unsigned       stall;
        bit                busy;
        bit                offered;
        logic              off_wen;
        dcache_pkg::word_t off_addr;
        dcache_pkg::word_t off_data;
        dwait   = 1'b1;
        dload   = '0;
        stall   = 0;
        busy    = 1'b0;
        offered = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            // transfer offered last cycle completed on this edge
            if (offered && off_wen) begin
                mem[off_addr] = off_data;
                if (flush_active) begin
                    if (flush_writes.exists(off_addr)) flush_writes[off_addr]++;
                    else flush_writes[off_addr] = 1;
                end
            end
            if (offered) busy = 1'b0;
            offered = 1'b0;
            if (!n_rst || !(dREN || dWEN)) begin
                busy  = 1'b0;
                dwait = 1'b1;
                dload = '0;
            end else begin
                if (!busy) begin
                    stall = $unsigned($random(seed)) % 4;
                    busy  = 1'b1;
                end
                if (stall > 0) begin
                    dwait = 1'b1;
                    stall--;
                end else begin
                    dwait    = 1'b0;
                    dload    = dREN ? mem_word(daddr) : '0;
                    offered  = 1'b1;
                    off_wen  = dWEN;
                    off_addr = daddr;
                    off_data = dstore;
                end
            end
        end
    end

    initial begin
        int errs;
        int cycles;
        n_rst        = 1'b0;
        halt         = 1'b0;
        dmemREN      = 1'b0;
        dmemWEN      = 1'b0;
        dmemaddr     = '0;
        dmemstore    = '0;
        seed         = 32'h3dbc;
        flush_active = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        load_golden();
        repeat (3) @(posedge CLK);
        #1;
        n_rst = 1'b1;

        errs = errors;
        check_value("dREN", 0, dREN);
        check_value("dWEN", 0, dWEN);
        check_value("dhit", 0, dhit);
        check_value("flushed", 0, flushed);
        check_value("daddr", 0, daddr);
        check_value("dstore", 0, dstore);
        finish_test("reset state", errs);

        for (int i = 0; i < op_kind.size() && !timed_out; i++) begin
            errs = errors;
            run_op(op_kind[i], op_addr[i], op_data[i]);
            finish_test($sformatf("%s 0x%08h", (op_kind[i] == "W") ? "write" : "read",
                                  op_addr[i]), errs);
        end

        if (!timed_out) begin
            errs         = errors;
            flush_active = 1'b1;
            halt         = 1'b1;
            cycles       = 0;
            @(negedge CLK);
            while (!flushed && cycles < WAIT_LIMIT) begin
                @(negedge CLK);
                cycles++;
            end
            if (!flushed) report_timeout("flushed");
            finish_test("flush", errs);
        end

        // last write-back landed at least one edge before flushed rose
        if (!timed_out) begin
            errs = errors;
            foreach (fin_addr[i]) begin
                check_value($sformatf("mem[0x%08h]", fin_addr[i]), fin_data[i],
                            mem_word(fin_addr[i]));
            end
            foreach (flush_writes[a]) begin
                check_value($sformatf("flush writes to 0x%08h", a), 1, flush_writes[a]);
            end
            finish_test("final memory", errs);
        end

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_ways.sv
hw/dcache_ctrl.sv
hw/dcache.sv
testbench/dcache_assert.sv
testbench/dcache_tb.sv

/* testbench/dcache_golden.txt */
# columns: kind (R read, W write, M memory after flush), byte address in hex, data in hex
# R data is the expected load, W data is the store, M data is the expected memory word
# set 1, read miss then the other word of the block
R 00000108 a5a50108
R 0000010c a5a5010c
W 0000010c 11112222
R 0000010c 11112222
# set 1, two more tags evict the dirty block, then refill it
R 00000208 a5a50208
R 00000308 a5a50308
R 0000010c 11112222
R 00000108 a5a50108
W 0000030c 77778888
# set 2, write misses in both ways
W 00000414 01234567
W 00000410 cafe0001
W 00000814 0badf00d
R 00000414 01234567
R 00000810 a5a50810
R 00000814 0badf00d
# sets 0, 5 and 7
W 00000044 deadbeef
R 00000040 a5a50040
W 00001028 55aa55aa
R 0000102c a5a5102c
R 00003838 a5a53838
# memory after the flush
M 00000108 a5a50108
M 0000010c 11112222
M 00000208 a5a50208
M 00000308 a5a50308
M 0000030c 77778888
M 00000410 cafe0001
M 00000414 01234567
M 00000810 a5a50810
M 00000814 0badf00d
M 00000040 a5a50040
M 00000044 deadbeef
M 00001028 55aa55aa
M 0000102c a5a5102c
M 00003838 a5a53838
